// ==== arb_req_if.sv ====
`include "router_params.svh"
`default_nettype none

// candidates from four sources into one output arbiter
interface arb_req_if
    import trans_pkg::*;
();

    logic        [`ROUTER_SRC_PER_ARB-1:0] cand_valid;   // request names this output
    t_tile_trans [`ROUTER_SRC_PER_ARB-1:0] cand_req;     // next hop already rewritten
    logic        [`ROUTER_SRC_PER_ARB-1:0] slot_ready;   // source fifo not full

    modport route (
        output cand_valid,
        output cand_req,
        input  slot_ready
    );

    modport arb (
        input  cand_valid,
        input  cand_req,
        output slot_ready
    );

endinterface

`default_nettype wire

// ==== input_fifo.sv ====
`include "router_params.svh"
`default_nettype none

module input_fifo
    import trans_pkg::*;
#(
    parameter int WIDTH = $bits(t_tile_trans),
    parameter int DEPTH = `ROUTER_FIFO_DEPTH
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              push,
    input  wire  [WIDTH-1:0] push_data,
    input  wire              pop,
    output logic [WIDTH-1:0] head,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;   // push on full is lost
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];     // head valid while !empty

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

// ==== mesh_pkg.sv ====
`include "router_params.svh"
`default_nettype none

package mesh_pkg;

    // port directions, values double as ready bit index
    typedef enum logic [2:0] {
        NORTH = 3'd0,
        EAST  = 3'd1,
        SOUTH = 3'd2,
        WEST  = 3'd3,
        LOCAL = 3'd4
    } t_cardinal;

    typedef struct packed {
        logic [`ROUTER_ID_W/2-1:0] col;   // upper nibble
        logic [`ROUTER_ID_W/2-1:0] row;   // lower nibble, north is row - 1
    } t_tile_id;

    // one bit per downstream arbiter, north_arb is bit 0
    typedef struct packed {
        logic local_arb;
        logic west_arb;
        logic south_arb;
        logic east_arb;
        logic north_arb;
    } t_fab_ready;

    // tile one step away in the given direction
    function automatic t_tile_id neighbor_of(t_tile_id here, t_cardinal dir);
        t_tile_id nb;
        nb = here;
        case (dir)
            NORTH:   nb.row = here.row - 1'b1;
            SOUTH:   nb.row = here.row + 1'b1;
            EAST:    nb.col = here.col + 1'b1;
            WEST:    nb.col = here.col - 1'b1;
            default: nb = here;   // local stays put
        endcase
        return nb;
    endfunction

    // source feeding a slot, order n e s w l minus the arbiter itself
    function automatic t_cardinal slot_src(t_cardinal arb, int unsigned slot);
        return (slot < int'(arb)) ? t_cardinal'(slot) : t_cardinal'(slot + 1);
    endfunction

endpackage

`default_nettype wire

// ==== mesh_router.f ====
+incdir+.
mesh_pkg.sv
trans_pkg.sv
arb_req_if.sv
route_stage.sv
input_fifo.sv
port_arbiter.sv
mesh_router.sv
mesh_router_assert.sv
mesh_router_tb.sv

// ==== mesh_router.sv ====
`default_nettype none

module mesh_router
    import mesh_pkg::*;
    import trans_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  var t_tile_id    local_tile_id,
    //============================================================
    // north
    //============================================================
    input  wire             in_north_req_valid,
    input  var t_tile_trans in_north_req,
    output t_fab_ready      out_north_ready,     // our arbiters, as seen by north
    output logic            out_north_req_valid,
    output t_tile_trans     out_north_req,
    input  var t_fab_ready  in_north_ready,      // arbiters in the north tile
    //============================================================
    // east
    //============================================================
    input  wire             in_east_req_valid,
    input  var t_tile_trans in_east_req,
    output t_fab_ready      out_east_ready,
    output logic            out_east_req_valid,
    output t_tile_trans     out_east_req,
    input  var t_fab_ready  in_east_ready,
    //============================================================
    // south
    //============================================================
    input  wire             in_south_req_valid,
    input  var t_tile_trans in_south_req,
    output t_fab_ready      out_south_ready,
    output logic            out_south_req_valid,
    output t_tile_trans     out_south_req,
    input  var t_fab_ready  in_south_ready,
    //============================================================
    // west
    //============================================================
    input  wire             in_west_req_valid,
    input  var t_tile_trans in_west_req,
    output t_fab_ready      out_west_ready,
    output logic            out_west_req_valid,
    output t_tile_trans     out_west_req,
    input  var t_fab_ready  in_west_ready,
    //============================================================
    // local
    //============================================================
    input  wire             in_local_req_valid,
    input  var t_tile_trans in_local_req,
    output t_fab_ready      out_local_ready,
    output logic            out_local_req_valid,
    output t_tile_trans     out_local_req,
    input  var t_fab_ready  in_local_ready
);

    arb_req_if north_if ();
    arb_req_if east_if  ();
    arb_req_if south_if ();
    arb_req_if west_if  ();
    arb_req_if local_if ();

    route_stage u_route (
        .local_tile_id (local_tile_id),
        .north_valid   (in_north_req_valid),
        .east_valid    (in_east_req_valid),
        .south_valid   (in_south_req_valid),
        .west_valid    (in_west_req_valid),
        .local_valid   (in_local_req_valid),
        .north_req     (in_north_req),
        .east_req      (in_east_req),
        .south_req     (in_south_req),
        .west_req      (in_west_req),
        .local_req     (in_local_req),
        .to_north      (north_if),
        .to_east       (east_if),
        .to_south      (south_if),
        .to_west       (west_if),
        .to_local      (local_if)
    );

    // slot of source d in arbiter o is d, or d-1 past o; own bit tied low
    assign out_north_ready = '{north_arb: 1'b0,                 east_arb: east_if.slot_ready[0],
                               south_arb: south_if.slot_ready[0], west_arb: west_if.slot_ready[0],
                               local_arb: local_if.slot_ready[0]};
    assign out_east_ready  = '{north_arb: north_if.slot_ready[0], east_arb: 1'b0,
                               south_arb: south_if.slot_ready[1], west_arb: west_if.slot_ready[1],
                               local_arb: local_if.slot_ready[1]};
    assign out_south_ready = '{north_arb: north_if.slot_ready[1], east_arb: east_if.slot_ready[1],
                               south_arb: 1'b0,                 west_arb: west_if.slot_ready[2],
                               local_arb: local_if.slot_ready[2]};
    assign out_west_ready  = '{north_arb: north_if.slot_ready[2], east_arb: east_if.slot_ready[2],
                               south_arb: south_if.slot_ready[2], west_arb: 1'b0,
                               local_arb: local_if.slot_ready[3]};
    assign out_local_ready = '{north_arb: north_if.slot_ready[3], east_arb: east_if.slot_ready[3],
                               south_arb: south_if.slot_ready[3], west_arb: west_if.slot_ready[3],
                               local_arb: 1'b0};

    //============================================================
    // one arbiter per output
    //============================================================
    port_arbiter u_north_arb (
        .clk (clk), .reset (reset), .cands (north_if), .down_ready (in_north_ready),
        .out_valid (out_north_req_valid), .out_req (out_north_req)
    );
    port_arbiter u_east_arb (
        .clk (clk), .reset (reset), .cands (east_if), .down_ready (in_east_ready),
        .out_valid (out_east_req_valid), .out_req (out_east_req)
    );
    port_arbiter u_south_arb (
        .clk (clk), .reset (reset), .cands (south_if), .down_ready (in_south_ready),
        .out_valid (out_south_req_valid), .out_req (out_south_req)
    );
    port_arbiter u_west_arb (
        .clk (clk), .reset (reset), .cands (west_if), .down_ready (in_west_ready),
        .out_valid (out_west_req_valid), .out_req (out_west_req)
    );
    port_arbiter u_local_arb (   // to the local core
        .clk (clk), .reset (reset), .cands (local_if), .down_ready (in_local_ready),
        .out_valid (out_local_req_valid), .out_req (out_local_req)
    );

endmodule

`default_nettype wire

// ==== mesh_router_assert.sv ====
`default_nettype none

// checks on the router top level, attached by bind
module mesh_router_assert
    import mesh_pkg::*;
    import trans_pkg::*;
(
    input wire             clk,
    input wire             reset,
    input wire             out_north_req_valid,
    input wire             out_east_req_valid,
    input wire             out_south_req_valid,
    input wire             out_west_req_valid,
    input wire             out_local_req_valid,
    input var t_tile_trans out_north_req,
    input var t_tile_trans out_east_req,
    input var t_tile_trans out_south_req,
    input var t_tile_trans out_west_req,
    input var t_fab_ready  out_north_ready,
    input var t_fab_ready  out_east_ready,
    input var t_fab_ready  out_south_ready,
    input var t_fab_ready  out_west_ready,
    input var t_fab_ready  out_local_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [4:0] any_valid;
    logic [4:0] own_ready;   // each port's bit toward itself

    assign any_valid = {out_local_req_valid, out_west_req_valid, out_south_req_valid,
                        out_east_req_valid, out_north_req_valid};
    assign own_ready = {out_local_ready.local_arb, out_west_ready.west_arb,
                        out_south_ready.south_arb, out_east_ready.east_arb,
                        out_north_ready.north_arb};

    // outputs quiet right after reset
    a_quiet: assert property (@(posedge clk) reset |=> any_valid == '0)
        else $error("output valid in the cycle after reset");

    //============================================================
    // XY never hands a request straight back
    //============================================================
    a_north_hop: assert property (@(posedge clk) disable iff (reset)
        out_north_req_valid |-> out_north_req.next_tile_fifo_arb_id != SOUTH)
        else $error("north output carries a SOUTH hop");
    a_east_hop: assert property (@(posedge clk) disable iff (reset)
        out_east_req_valid |-> out_east_req.next_tile_fifo_arb_id != WEST)
        else $error("east output carries a WEST hop");
    a_south_hop: assert property (@(posedge clk) disable iff (reset)
        out_south_req_valid |-> out_south_req.next_tile_fifo_arb_id != NORTH)
        else $error("south output carries a NORTH hop");
    a_west_hop: assert property (@(posedge clk) disable iff (reset)
        out_west_req_valid |-> out_west_req.next_tile_fifo_arb_id != EAST)
        else $error("west output carries an EAST hop");

    // u-turn slot does not exist
    a_own_ready: assert property (@(posedge clk) own_ready == '0)
        else $error("a port offers ready toward its own direction");

endmodule

bind mesh_router mesh_router_assert u_assert (.*);

`default_nettype wire

// ==== mesh_router_tb.sv ====
`include "router_params.svh"
`default_nettype none

module mesh_router_tb
    import mesh_pkg::*;
    import trans_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int       DEPTH = `ROUTER_FIFO_DEPTH;
    localparam t_tile_id HOME  = '{col: 4'h5, row: 4'h6};   // mid-array, no edge wrap

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid  [5];   // all arrays indexed by t_cardinal
    t_tile_trans in_req    [5];
    t_fab_ready  out_ready [5];
    logic        out_valid [5];
    t_tile_trans out_req   [5];
    t_fab_ready  in_ready  [5];

    t_tile_trans exp_q [25][$];   // output * 5 + source
    int          fair_seq [$];    // sources seen on out_local
    bit          hold_en;         // east must not send NORTH hops
    bit          fair_on;
    int          value_errs = 0;
    int          other_errs = 0;

    always #50 clk = ~clk;

    mesh_router u_dut (
        .clk (clk), .reset (reset), .local_tile_id (HOME),
        .in_north_req_valid (in_valid[NORTH]), .in_north_req (in_req[NORTH]),
        .out_north_ready (out_ready[NORTH]), .out_north_req_valid (out_valid[NORTH]),
        .out_north_req (out_req[NORTH]), .in_north_ready (in_ready[NORTH]),
        .in_east_req_valid (in_valid[EAST]), .in_east_req (in_req[EAST]),
        .out_east_ready (out_ready[EAST]), .out_east_req_valid (out_valid[EAST]),
        .out_east_req (out_req[EAST]), .in_east_ready (in_ready[EAST]),
        .in_south_req_valid (in_valid[SOUTH]), .in_south_req (in_req[SOUTH]),
        .out_south_ready (out_ready[SOUTH]), .out_south_req_valid (out_valid[SOUTH]),
        .out_south_req (out_req[SOUTH]), .in_south_ready (in_ready[SOUTH]),
        .in_west_req_valid (in_valid[WEST]), .in_west_req (in_req[WEST]),
        .out_west_ready (out_ready[WEST]), .out_west_req_valid (out_valid[WEST]),
        .out_west_req (out_req[WEST]), .in_west_ready (in_ready[WEST]),
        .in_local_req_valid (in_valid[LOCAL]), .in_local_req (in_req[LOCAL]),
        .out_local_ready (out_ready[LOCAL]), .out_local_req_valid (out_valid[LOCAL]),
        .out_local_req (out_req[LOCAL]), .in_local_ready (in_ready[LOCAL])
    );

    //============================================================
    // reference model, XY hop from the tile beyond out_dir
    //============================================================
    function automatic t_cardinal exp_hop(t_tile_id here, t_cardinal out_dir,
                                          logic [31:0] addr);
        int col;
        int row;
        int tcol;
        int trow;
        col  = int'(here.col);
        row  = int'(here.row);
        tcol = int'(addr[`ROUTER_TARGET_MSB -: 4]);   // column nibble
        trow = int'(addr[`ROUTER_TARGET_LSB +: 4]);
        if (out_dir == LOCAL)
            return LOCAL;   // delivered in this tile
        if (out_dir == NORTH) row = (row + 15) % 16;   // north is a smaller row
        if (out_dir == SOUTH) row = (row + 1) % 16;
        if (out_dir == EAST)  col = (col + 1) % 16;
        if (out_dir == WEST)  col = (col + 15) % 16;
        if (tcol != col)
            return (tcol > col) ? EAST : WEST;
        if (trow != row)
            return (trow > row) ? SOUTH : NORTH;
        return LOCAL;
    endfunction

    // target that XY sends out through o, ranges assume HOME at 5,6
    function automatic t_tile_id pick_target(t_cardinal o);
        t_tile_id t;
        t = HOME;
        case (o)
            EAST:    t = '{col: 4'(6 + $urandom % 10), row: 4'($urandom % 16)};
            WEST:    t = '{col: 4'($urandom % 5), row: 4'($urandom % 16)};
            NORTH:   t.row = 4'($urandom % 6);
            SOUTH:   t.row = 4'(7 + $urandom % 9);
            default: t = HOME;
        endcase
        return t;
    endfunction

    task automatic check_trans(string name, t_tile_trans got, t_tile_trans exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_ready(string name, t_fab_ready got, t_fab_ready exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_valid(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic idle_inputs();
        for (int d = 0; d < 5; d++)
            in_valid[d] = 1'b0;
    endtask

    // drive one request from port d if its ready bit allows, log the expected copy
    task automatic offer(input int d, input t_cardinal o, input t_tile_id tgt,
                         output bit taken);
        t_tile_trans t;
        logic [4:0]  rdy;
        rdy   = out_ready[d];
        taken = rdy[o];
        if (taken) begin
            t.address               = {tgt, 24'($urandom)};
            t.data                  = $urandom;
            t.opcode                = t_opcode'(2'($urandom % 4));
            t.requestor_id          = '{col: 4'h0, row: 4'(d)};   // source tag
            t.next_tile_fifo_arb_id = o;
            in_req[d]   = t;
            in_valid[d] = 1'b1;
            t.next_tile_fifo_arb_id = exp_hop(HOME, o, t.address);
            exp_q[int'(o) * 5 + d].push_back(t);
        end
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < 25; i++)
            n += exp_q[i].size();
        return n;
    endfunction

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (pending() != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (pending() != 0) begin
            $display("Timeout: %0d accepted requests never left the router", pending());
            other_errs++;
        end
    endtask

    //============================================================
    // scoreboard, outputs sampled mid-cycle
    //============================================================
    always @(negedge clk) begin
        int src;
        if (!reset) begin
            for (int o = 0; o < 5; o++) begin
                if (out_valid[o]) begin
                    src = int'(out_req[o].requestor_id.row);   // tag set per input port
                    if (src > 4 || src == o || exp_q[o * 5 + src].size() == 0) begin
                        $display("Output %0d delivered a request that was never sent", o);
                        other_errs++;
                    end else begin
                        check_trans($sformatf("out_req[%0d]", o), out_req[o],
                                    exp_q[o * 5 + src].pop_front());
                    end
                    if (hold_en && o == int'(EAST)
                        && out_req[o].next_tile_fifo_arb_id == NORTH) begin
                        $display("East output sent a NORTH hop while blocked downstream");
                        other_errs++;
                    end
                    if (fair_on && o == int'(LOCAL))
                        fair_seq.push_back(src);
                end
            end
        end
    end

    initial begin
        bit         taken;
        bit         seen;
        int         accepts;
        int         lat;
        logic [4:0] rdy;
        t_cardinal  o;
        void'($urandom(32'h35ba_9969));
        reset   = 1'b1;
        hold_en = 1'b0;
        fair_on = 1'b0;
        for (int d = 0; d < 5; d++) begin
            in_valid[d] = 1'b0;
            in_req[d]   = '0;
            in_ready[d] = '1;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset state
        @(negedge clk);
        for (int d = 0; d < 5; d++) begin
            rdy    = '1;
            rdy[d] = 1'b0;   // own direction
            check_ready($sformatf("out_ready[%0d]", d), out_ready[d], t_fab_ready'(rdy));
            check_valid($sformatf("out_valid[%0d]", d), out_valid[d], 1'b0);
        end

        // single far request, latency in falling edges from drive
        @(negedge clk);
        offer(LOCAL, EAST, '{col: 4'hc, row: 4'h2}, taken);
        lat  = 0;
        seen = 1'b0;
        while (taken && !seen && lat < 20) begin
            @(negedge clk);
            idle_inputs();
            lat++;
            seen = out_valid[EAST];
        end
        if (!seen) begin
            $display("Single local request never appeared on the east output");
            other_errs++;
        end else if (lat != 2) begin
            $display("Single request took %0d cycles instead of 2", lat);
            other_errs++;
        end
        wait_drain(20);

        // random traffic, all downstream ready
        for (int c = 0; c < 300; c++) begin
            @(negedge clk);
            idle_inputs();
            for (int d = 0; d < 5; d++) begin
                o = t_cardinal'(3'($urandom % 5));
                if (int'(o) != d && $urandom % 3 != 0)
                    offer(d, o, pick_target(o), taken);
            end
        end
        @(negedge clk);
        idle_inputs();
        wait_drain(200);

        //============================================================
        // back-pressure on east, NORTH hops held
        //============================================================
        hold_en                  = 1'b1;
        in_ready[EAST].north_arb = 1'b0;
        accepts                  = 0;
        for (int c = 0; c < DEPTH + 3; c++) begin
            @(negedge clk);
            idle_inputs();
            offer(LOCAL, EAST, '{col: 4'h6, row: 4'(c % 6)}, taken);   // NORTH beyond east
            accepts += int'(taken);
            offer(WEST, EAST, '{col: 4'h9, row: 4'h3}, taken);   // EAST hop, not held
        end
        @(negedge clk);
        idle_inputs();
        repeat (6) @(negedge clk);
        if (accepts != DEPTH || pending() != DEPTH) begin
            $display("Blocked slot took %0d requests, %0d still queued", accepts, pending());
            other_errs++;
        end
        check_ready("out_ready[4]", out_ready[LOCAL], t_fab_ready'(5'b01101));
        in_ready[EAST].north_arb = 1'b1;
        hold_en                  = 1'b0;
        wait_drain(100);
        check_ready("out_ready[4]", out_ready[LOCAL], t_fab_ready'(5'b01111));

        // fairness, fill all four local slots then release
        in_ready[LOCAL].local_arb = 1'b0;
        for (int c = 0; c < DEPTH; c++) begin
            @(negedge clk);
            idle_inputs();
            for (int d = 0; d < 4; d++)
                offer(d, LOCAL, HOME, taken);
        end
        @(negedge clk);
        idle_inputs();
        fair_on                   = 1'b1;
        in_ready[LOCAL].local_arb = 1'b1;
        wait_drain(100);
        fair_on = 1'b0;
        if (fair_seq.size() != 4 * DEPTH) begin
            $display("Local output granted %0d requests instead of %0d",
                     fair_seq.size(), 4 * DEPTH);
            other_errs++;
        end
        for (int i = 1; i < fair_seq.size(); i++) begin
            if (fair_seq[i] != (fair_seq[i - 1] + 1) % 4) begin
                $display("Local grant %0d went to source %0d out of turn", i, fair_seq[i]);
                other_errs++;
            end
        end

        repeat (4) @(negedge clk);
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== port_arbiter.sv ====
`include "router_params.svh"
`default_nettype none

module port_arbiter
    import mesh_pkg::*;
    import trans_pkg::*;
(
    input  wire            clk,
    input  wire            reset,
    arb_req_if.arb         cands,
    input  var t_fab_ready down_ready,   // arbiters of the downstream tile
    output logic           out_valid,
    output t_tile_trans    out_req
);

    localparam int N_SRC = `ROUTER_SRC_PER_ARB;
    localparam int IDX_W = $clog2(N_SRC);

    logic [$bits(t_fab_ready)-1:0] ready_vec;   // indexed by t_cardinal
    t_tile_trans                   head [N_SRC];
    logic        [N_SRC-1:0]       empty;
    logic        [N_SRC-1:0]       full;
    logic        [N_SRC-1:0]       eligible;
    logic        [N_SRC-1:0]       pop;
    logic        [IDX_W-1:0]       rr_ptr;      // first slot to look at
    logic        [IDX_W-1:0]       winner;
    logic                          any_win;

    assign ready_vec        = down_ready;
    assign cands.slot_ready = ~full;

    //============================================================
    // one fifo per source slot
    //============================================================
    for (genvar s = 0; s < N_SRC; s++) begin : g_slot
        input_fifo u_fifo (
            .clk       (clk),
            .reset     (reset),
            .push      (cands.cand_valid[s] && !full[s]),
            .push_data (cands.cand_req[s]),
            .pop       (pop[s]),
            .head      (head[s]),
            .empty     (empty[s]),
            .full      (full[s])
        );
        // head only goes if its next arbiter has room
        assign eligible[s] = !empty[s] && ready_vec[head[s].next_tile_fifo_arb_id];
    end

    //============================================================
    // round robin from rr_ptr
    //============================================================
    always_comb begin
        int idx;
        any_win = 1'b0;
        winner  = rr_ptr;
        for (int i = 0; i < N_SRC; i++) begin
            idx = (int'(rr_ptr) + i) % N_SRC;   // cyclic scan
            if (!any_win && eligible[idx]) begin
                any_win = 1'b1;
                winner  = IDX_W'(idx);
            end
        end
    end

    always_comb begin
        pop = '0;
        if (any_win)
            pop[winner] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            rr_ptr    <= '0;
        end else begin
            out_valid <= any_win;   // one cycle per grant
            if (any_win)
                rr_ptr <= (winner == IDX_W'(N_SRC - 1)) ? '0 : winner + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (any_win)
            out_req <= head[winner];
    end

endmodule

`default_nettype wire

// ==== route_stage.sv ====
`include "router_params.svh"
`default_nettype none

module route_stage
    import mesh_pkg::*;
    import trans_pkg::*;
(
    input  var t_tile_id    local_tile_id,
    input  wire             north_valid,
    input  wire             east_valid,
    input  wire             south_valid,
    input  wire             west_valid,
    input  wire             local_valid,
    input  var t_tile_trans north_req,
    input  var t_tile_trans east_req,
    input  var t_tile_trans south_req,
    input  var t_tile_trans west_req,
    input  var t_tile_trans local_req,
    arb_req_if.route        to_north,
    arb_req_if.route        to_east,
    arb_req_if.route        to_south,
    arb_req_if.route        to_west,
    arb_req_if.route        to_local
);

    localparam int N_PORTS = `ROUTER_SRC_PER_ARB + 1;

    logic        [N_PORTS-1:0]             valid_vec;      // indexed by t_cardinal
    t_tile_trans                           req_vec [N_PORTS];
    logic        [`ROUTER_SRC_PER_ARB-1:0] cand_v  [N_PORTS];
    t_tile_trans [`ROUTER_SRC_PER_ARB-1:0] cand_r  [N_PORTS];

    // XY hop as seen from the tile beyond out_dir
    function automatic t_cardinal xy_hop(t_tile_id here, t_cardinal out_dir,
                                         t_tile_id target);
        t_tile_id  nb;
        t_cardinal hop;
        nb = neighbor_of(here, out_dir);
        if (out_dir == LOCAL)         hop = LOCAL;   // delivered here
        else if (target.col > nb.col) hop = EAST;    // column first
        else if (target.col < nb.col) hop = WEST;
        else if (target.row > nb.row) hop = SOUTH;   // then row
        else if (target.row < nb.row) hop = NORTH;
        else                          hop = LOCAL;
        return hop;
    endfunction

    assign valid_vec = {local_valid, west_valid, south_valid, east_valid, north_valid};
    assign req_vec   = '{north_req, east_req, south_req, west_req, local_req};

    //============================================================
    // match and rewrite, every output, every slot
    //============================================================
    always_comb begin
        t_cardinal src;
        for (int o = 0; o < N_PORTS; o++) begin
            for (int s = 0; s < `ROUTER_SRC_PER_ARB; s++) begin
                src = slot_src(t_cardinal'(o), s);   // own direction never a source
                cand_v[o][s] = valid_vec[src]
                            && (req_vec[src].next_tile_fifo_arb_id == t_cardinal'(o));
                cand_r[o][s] = req_vec[src];
                cand_r[o][s].next_tile_fifo_arb_id = xy_hop(local_tile_id, t_cardinal'(o),
                    t_tile_id'(req_vec[src].address[`ROUTER_TARGET_MSB:`ROUTER_TARGET_LSB]));
            end
        end
    end

    assign to_north.cand_valid = cand_v[NORTH];
    assign to_north.cand_req   = cand_r[NORTH];
    assign to_east.cand_valid  = cand_v[EAST];
    assign to_east.cand_req    = cand_r[EAST];
    assign to_south.cand_valid = cand_v[SOUTH];
    assign to_south.cand_req   = cand_r[SOUTH];
    assign to_west.cand_valid  = cand_v[WEST];
    assign to_west.cand_req    = cand_r[WEST];
    assign to_local.cand_valid = cand_v[LOCAL];
    assign to_local.cand_req   = cand_r[LOCAL];

endmodule

`default_nettype wire

// ==== router_params.svh ====
`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

//============================================================
// router sizing
//============================================================
`define ROUTER_FIFO_DEPTH   4   // entries per source slot

`define ROUTER_ADDR_W       32
`define ROUTER_DATA_W       32
`define ROUTER_ID_W         8   // column nibble, row nibble

// target tile id inside the address
`define ROUTER_TARGET_MSB   31
`define ROUTER_TARGET_LSB   24

// sources queued by one output arbiter, all ports but its own
`define ROUTER_SRC_PER_ARB  4

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mesh router testbench with verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mesh_router_tb -f mesh_router.f -o mesh_router_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/mesh_router_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// ==== trans_pkg.sv ====
`include "router_params.svh"
`default_nettype none

package trans_pkg;
    import mesh_pkg::*;

    // carried through untouched
    typedef enum logic [1:0] {
        RD     = 2'd0,
        WR     = 2'd1,
        RD_RSP = 2'd2,
        WR_RSP = 2'd3
    } t_opcode;

    //============================================================
    // one router transaction, 77 bits
    //============================================================
    typedef struct packed {
        logic [`ROUTER_ADDR_W-1:0] address;   // target tile in the top byte
        logic [`ROUTER_DATA_W-1:0] data;
        t_opcode                   opcode;
        t_tile_id                  requestor_id;
        t_cardinal                 next_tile_fifo_arb_id;   // arbiter in the next tile
    } t_tile_trans;

endpackage

`default_nettype wire
